// ==== Makefile ====
# Verilator simulation of the PSG testbench
# the run passes only if the log holds the pass line

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build psg_tb with Verilator, run it, search $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f compile.f --top-module psg_tb -Mdir obj_dir
	./obj_dir/Vpsg_tb | tee $(LOG)
	grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+include
logic/psg_pkg.sv
logic/psg_clock_div.sv
logic/psg_period_div.sv
logic/psg_tone_noise.sv
logic/psg_envelope.sv
logic/psg_mixer.sv
logic/psg_top.sv
testbench/psg_tb.sv

// ==== logic/psg_clock_div.sv ====
// ================================================
// enables are registered, one clk wide
// sel low halves both rates
// ================================================
`timescale 1ns/1ps

module psg_clock_div (
    input  logic clk,
    input  logic rst_n,
    input  logic clk_en,
    input  logic sel,
    output logic cen16,
    output logic cen256
);

    logic [7:0] cnt;   // free-running prescaler
    logic       half;  // alternates every clk_en
    logic       adv;

    assign adv = clk_en && (sel || half);  // skip every other enable when sel low

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            half   <= 1'b0;
            cen16  <= 1'b0;
            cen256 <= 1'b0;
        end else begin
            if (clk_en) half <= ~half;
            if (adv) cnt <= cnt + 1'b1;
            cen16  <= adv && (cnt[3:0] == 4'hf);  // carry out of bit 3
            cen256 <= adv && (cnt == 8'hff);      // carry out of bit 7
        end
    end

    a_cen256_in_cen16: assert property (@(posedge clk) disable iff (!rst_n) cen256 |-> cen16);

endmodule

// ==== logic/psg_envelope.sv ====
// ================================================
// steps are edges of the cen256 divider seen on cen16
// restart wins over a step in the same clk
// shape bits 3..0 are continue, attack, alt, hold
// ================================================
`timescale 1ns/1ps

module psg_envelope import psg_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen16,
    input  logic        cen256,
    input  env_period_t env_period,
    input  env_shape_t  shape,
    input  logic        env_restart,
    output level_t      env_level
);

    env_state_t state;
    logic       step_div;  // divider output level
    logic       div_q;     // its value at the last cen16
    logic       step;
    logic       dir;       // 1 counts up
    logic       at_end;
    logic       cont, attack, alt, hold;

    assign cont   = shape[3];
    assign attack = shape[2];
    assign alt    = shape[1];
    assign hold   = shape[0];

    psg_env_div u_step_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen256),
        .period (env_period),
        .div    (step_div)
    );

    assign step   = cen16 && (step_div != div_q);
    assign at_end = dir ? (env_level == '1) : (env_level == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ENV_HOLD;
            env_level <= '0;
            dir       <= 1'b0;
            div_q     <= 1'b0;
        end else begin
            if (cen16) div_q <= step_div;
            if (env_restart) begin
                state     <= ENV_RUN;
                dir       <= attack;
                env_level <= attack ? '0 : '1;  // attack starts low
            end else if (step && state == ENV_RUN) begin
                if (!at_end) begin
                    env_level <= dir ? level_t'(env_level + 1'b1) : level_t'(env_level - 1'b1);
                end else if (!cont) begin
                    state     <= ENV_HOLD;  // single ramp, then silent
                    env_level <= '0;
                end else if (hold) begin
                    state     <= ENV_HOLD;
                    env_level <= (dir ^ alt) ? '1 : '0;  // alt holds the start level
                end else if (alt) begin
                    dir <= ~dir;  // bounce back from the end
                end else begin
                    env_level <= dir ? '0 : '1;  // sawtooth wrap
                end
            end
        end
    end

    // only a restart from psg_top may move a held level
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ENV_HOLD && !env_restart) |=> $stable(env_level));

endmodule

// ==== logic/psg_mixer.sv ====
// ================================================
// two register stages, both on clk_en
// a_out, b_out, c_out decode stage 2 directly
// sound lags them by one more clk_en
// ================================================
`timescale 1ns/1ps

module psg_mixer import psg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clk_en,
    input  logic      tone_a,
    input  logic      tone_b,
    input  logic      tone_c,
    input  logic      noise,
    input  logic [5:0] mix_ctrl,  // 2..0 tone off, 5..3 noise off
    input  reg_byte_t vol_a,
    input  reg_byte_t vol_b,
    input  reg_byte_t vol_c,
    input  level_t    env_level,
    output amp_t      a_out,
    output amp_t      b_out,
    output amp_t      c_out,
    output mix_sum_t  sound
);

    logic        on_a, on_b, on_c;        // stage 1 gates
    logic [4:0]  v1_a, v1_b, v1_c;        // stage 1 volume, bit 4 selects envelope
    level_t      env1;
    level_t      lvl_a, lvl_b, lvl_c;     // stage 2 levels

    // fixed volume widened by repeating its top bit
    function automatic level_t pick(input logic on, input logic [4:0] v, input level_t env);
        if (!on)
            return '0;
        return v[4] ? env : {v[3:0], v[3]};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            on_a  <= 1'b0;
            on_b  <= 1'b0;
            on_c  <= 1'b0;
            v1_a  <= '0;
            v1_b  <= '0;
            v1_c  <= '0;
            env1  <= '0;
            lvl_a <= '0;
            lvl_b <= '0;
            lvl_c <= '0;
            sound <= '0;
        end else if (clk_en) begin
            on_a  <= (tone_a | mix_ctrl[0]) & (noise | mix_ctrl[3]);
            on_b  <= (tone_b | mix_ctrl[1]) & (noise | mix_ctrl[4]);
            on_c  <= (tone_c | mix_ctrl[2]) & (noise | mix_ctrl[5]);
            v1_a  <= vol_a[4:0];
            v1_b  <= vol_b[4:0];
            v1_c  <= vol_c[4:0];
            env1  <= env_level;
            lvl_a <= pick(on_a, v1_a, env1);
            lvl_b <= pick(on_b, v1_b, env1);
            lvl_c <= pick(on_c, v1_c, env1);
            sound <= mix_sum_t'(a_out) + mix_sum_t'(b_out) + mix_sum_t'(c_out);
        end
    end

    // log to linear
    assign a_out = LIN_TABLE[lvl_a];
    assign b_out = LIN_TABLE[lvl_b];
    assign c_out = LIN_TABLE[lvl_c];

endmodule

// ==== logic/psg_period_div.sv ====
// ================================================
// period 0 behaves as period 1
// div toggles once every period enables
// ================================================
`timescale 1ns/1ps

module psg_tone_div import psg_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cen,
    input  tone_period_t period,
    output logic         div
);

    tone_period_t cnt;
    tone_period_t last;  // count at which div flips

    assign last = (period == '0) ? '0 : period - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            div <= 1'b0;
        end else if (cen) begin
            if (cnt >= last) begin  // >= so a shrinking period never stalls
                cnt <= '0;
                div <= ~div;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

module psg_env_div import psg_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  env_period_t period,
    output logic        div
);

    env_period_t cnt;
    env_period_t last;

    assign last = (period == '0) ? '0 : period - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            div <= 1'b0;
        end else if (cen) begin
            if (cnt >= last) begin
                cnt <= '0;
                div <= ~div;  // both edges count as steps downstream
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/psg_pkg.sv ====
// ================================================
// shared widths, register map and level table
// level table is a log scale, about 1.5 dB per step
// entry 0 is forced to silence
// ================================================
package psg_pkg;

    localparam int ADDR_W  = 4;
    localparam int BYTE_W  = 8;
    localparam int TONE_W  = 12;  // tone half-period
    localparam int NOISE_W = 5;
    localparam int ENV_W   = 16;  // envelope step period
    localparam int SHAPE_W = 4;
    localparam int LEVEL_W = 5;
    localparam int AMP_W   = 8;
    localparam int SUM_W   = 10;  // three amplitudes, no overflow
    localparam int LFSR_W  = 17;

    typedef logic [ADDR_W-1:0]  reg_addr_t;
    typedef logic [BYTE_W-1:0]  reg_byte_t;
    typedef logic [TONE_W-1:0]  tone_period_t;
    typedef logic [NOISE_W-1:0] noise_period_t;
    typedef logic [ENV_W-1:0]   env_period_t;
    typedef logic [SHAPE_W-1:0] env_shape_t;  // continue, attack, alternate, hold
    typedef logic [LEVEL_W-1:0] level_t;
    typedef logic [AMP_W-1:0]   amp_t;
    typedef logic [SUM_W-1:0]   mix_sum_t;

    typedef enum logic {ENV_RUN, ENV_HOLD} env_state_t;

    localparam reg_addr_t REG_TONE_A_LO = 4'h0, REG_TONE_A_HI = 4'h1;
    localparam reg_addr_t REG_TONE_B_LO = 4'h2, REG_TONE_B_HI = 4'h3;
    localparam reg_addr_t REG_TONE_C_LO = 4'h4, REG_TONE_C_HI = 4'h5;
    localparam reg_addr_t REG_NOISE     = 4'h6, REG_MIXER     = 4'h7;
    localparam reg_addr_t REG_VOL_A     = 4'h8, REG_VOL_B     = 4'h9;
    localparam reg_addr_t REG_VOL_C     = 4'ha, REG_ENV_LO    = 4'hb;
    localparam reg_addr_t REG_ENV_HI    = 4'hc, REG_ENV_SHAPE = 4'hd;
    localparam reg_addr_t REG_IO_A      = 4'he, REG_IO_B      = 4'hf;

    localparam amp_t LIN_TABLE [0:31] = '{
        8'd0,   8'd1,   8'd2,   8'd2,   8'd2,   8'd3,   8'd3,   8'd4,
        8'd5,   8'd6,   8'd7,   8'd8,   8'd10,  8'd11,  8'd14,  8'd16,
        8'd19,  8'd23,  8'd27,  8'd32,  8'd38,  8'd45,  8'd54,  8'd64,
        8'd76,  8'd90,  8'd108, 8'd128, 8'd152, 8'd181, 8'd215, 8'd255
    };

endpackage

// ==== logic/psg_tone_noise.sv ====
// ================================================
// tones and noise step on cen16 only
// noise steps every period ticks, twice the rate
// of a tone at the same period
// ================================================
`timescale 1ns/1ps

module psg_tone_noise import psg_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cen16,
    input  tone_period_t  period_a,
    input  tone_period_t  period_b,
    input  tone_period_t  period_c,
    input  noise_period_t noise_period,
    output logic          tone_a,
    output logic          tone_b,
    output logic          tone_c,
    output logic          noise
);

    noise_period_t        ncnt;      // noise period counter
    noise_period_t        nlast;
    logic [LFSR_W-1:0]    lfsr;
    logic                 fb;

    psg_tone_div u_div_a (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen16),
        .period (period_a),
        .div    (tone_a)
    );

    psg_tone_div u_div_b (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen16),
        .period (period_b),
        .div    (tone_b)
    );

    psg_tone_div u_div_c (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen16),
        .period (period_c),
        .div    (tone_c)
    );

    // zero period acts as one, like the tones
    assign nlast = (noise_period == '0) ? '0 : noise_period - 1'b1;
    assign fb    = lfsr[0] ^ lfsr[3];  // taps 0 and 3
    assign noise = lfsr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ncnt <= '0;
            lfsr <= LFSR_W'(1);  // any nonzero seed works
        end else if (cen16) begin
            if (ncnt >= nlast) begin
                ncnt <= '0;
                lfsr <= {fb, lfsr[LFSR_W-1:1]};  // shift right, feed top
            end else begin
                ncnt <= ncnt + 1'b1;
            end
        end
    end

    // xor feedback keeps a nonzero register nonzero
    a_lfsr_live: assert property (@(posedge clk) disable iff (!rst_n) lfsr != '0);

endmodule

// ==== logic/psg_top.sv ====
// ================================================
// bus pins are not multiplexed
// writes land on the clk where cs_n and wr_n are low
// dout is registered, valid one clk after cs_n low
// ================================================
`timescale 1ns/1ps

module psg_top import psg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clk_en,
    input  logic      sel,
    input  reg_addr_t addr,
    input  logic      cs_n,
    input  logic      wr_n,
    input  reg_byte_t din,
    input  reg_byte_t ioa_in,
    input  reg_byte_t iob_in,
    output reg_byte_t dout,
    output mix_sum_t  sound,
    output amp_t      a_out,
    output amp_t      b_out,
    output amp_t      c_out,
    output reg_byte_t ioa_out,
    output reg_byte_t iob_out
);

    reg_byte_t regs [16];
    reg_byte_t read_mask;
    reg_byte_t rd_data;
    logic      env_restart;
    logic      cen16, cen256;
    logic      tone_a, tone_b, tone_c, noise;
    level_t    env_level;

    assign ioa_out = regs[REG_IO_A];
    assign iob_out = regs[REG_IO_B];

    // unimplemented bits read as zero
    always_comb begin
        case (addr)
            REG_TONE_A_HI, REG_TONE_B_HI, REG_TONE_C_HI, REG_ENV_SHAPE: read_mask = 8'h0f;
            REG_NOISE, REG_VOL_A, REG_VOL_B, REG_VOL_C:                 read_mask = 8'h1f;
            default:                                                    read_mask = 8'hff;
        endcase
    end

    // ports set as inputs return the pins
    always_comb begin
        rd_data = regs[addr] & read_mask;
        if (addr == REG_IO_A && !regs[REG_MIXER][6])
            rd_data = ioa_in;
        if (addr == REG_IO_B && !regs[REG_MIXER][7])
            rd_data = iob_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
            dout        <= '0;
            env_restart <= 1'b0;
        end else begin
            env_restart <= !cs_n && (addr == REG_ENV_SHAPE);  // read or write restarts
            if (!cs_n) begin
                dout <= rd_data;
                if (!wr_n)
                    regs[addr] <= din;
            end
        end
    end

    psg_clock_div u_clock_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .sel    (sel),
        .cen16  (cen16),
        .cen256 (cen256)
    );

    psg_tone_noise u_tone_noise (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen16        (cen16),
        .period_a     ({regs[REG_TONE_A_HI][3:0], regs[REG_TONE_A_LO]}),
        .period_b     ({regs[REG_TONE_B_HI][3:0], regs[REG_TONE_B_LO]}),
        .period_c     ({regs[REG_TONE_C_HI][3:0], regs[REG_TONE_C_LO]}),
        .noise_period (regs[REG_NOISE][4:0]),
        .tone_a       (tone_a),
        .tone_b       (tone_b),
        .tone_c       (tone_c),
        .noise        (noise)
    );

    psg_envelope u_envelope (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen16       (cen16),
        .cen256      (cen256),
        .env_period  ({regs[REG_ENV_HI], regs[REG_ENV_LO]}),
        .shape       (regs[REG_ENV_SHAPE][3:0]),
        .env_restart (env_restart),
        .env_level   (env_level)
    );

    psg_mixer u_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .tone_a    (tone_a),
        .tone_b    (tone_b),
        .tone_c    (tone_c),
        .noise     (noise),
        .mix_ctrl  (regs[REG_MIXER][5:0]),
        .vol_a     (regs[REG_VOL_A]),
        .vol_b     (regs[REG_VOL_B]),
        .vol_c     (regs[REG_VOL_C]),
        .env_level (env_level),
        .a_out     (a_out),
        .b_out     (b_out),
        .c_out     (c_out),
        .sound     (sound)
    );

endmodule

// ==== include/psg_tb_vectors.svh ====
// ================================================
// one row per bus action or check, run in order
// columns are op, addr, data, value
// value is the expected byte, level, spacing or wait
// rows assume clk_en and sel held high
// ================================================
`ifndef PSG_TB_VECTORS_SVH
`define PSG_TB_VECTORS_SVH

typedef enum logic [2:0] {
    OP_WR,     // write data to addr
    OP_RD,     // read addr, dout equals value
    OP_PIN,    // read an input port, dout equals the pins
    OP_VOL,    // data to all three volumes, value is the level
    OP_MEAS,   // clocks between rising edges of a_out
    OP_WAIT,   // value clocks
    OP_AMP,    // a_out equals value
    OP_BELOW   // a_out below value
} op_t;

typedef struct packed {
    op_t         op;
    reg_addr_t   addr;
    reg_byte_t   data;
    logic [15:0] value;
} vec_row_t;

localparam int NUM_VECTORS = 68;

localparam vec_row_t VECTORS [NUM_VECTORS] = '{
    // fill every register, then ports as inputs
    '{OP_WR, 4'h0, 8'hff, 16'd0},    '{OP_WR, 4'h1, 8'hff, 16'd0},
    '{OP_WR, 4'h2, 8'hff, 16'd0},    '{OP_WR, 4'h3, 8'hff, 16'd0},
    '{OP_WR, 4'h4, 8'hff, 16'd0},    '{OP_WR, 4'h5, 8'hff, 16'd0},
    '{OP_WR, 4'h6, 8'hff, 16'd0},    '{OP_WR, 4'h7, 8'hff, 16'd0},
    '{OP_WR, 4'h8, 8'hff, 16'd0},    '{OP_WR, 4'h9, 8'hff, 16'd0},
    '{OP_WR, 4'ha, 8'hff, 16'd0},    '{OP_WR, 4'hb, 8'hff, 16'd0},
    '{OP_WR, 4'hc, 8'hff, 16'd0},    '{OP_WR, 4'hd, 8'hff, 16'd0},
    '{OP_WR, 4'he, 8'hff, 16'd0},    '{OP_WR, 4'hf, 8'hff, 16'd0},
    '{OP_WR, 4'h7, 8'h00, 16'd0},
    // read back through the masks
    '{OP_RD, 4'h0, 8'h00, 16'hff},   '{OP_RD, 4'h1, 8'h00, 16'h0f},
    '{OP_RD, 4'h2, 8'h00, 16'hff},   '{OP_RD, 4'h3, 8'h00, 16'h0f},
    '{OP_RD, 4'h4, 8'h00, 16'hff},   '{OP_RD, 4'h5, 8'h00, 16'h0f},
    '{OP_RD, 4'h6, 8'h00, 16'h1f},   '{OP_RD, 4'h7, 8'h00, 16'h00},
    '{OP_RD, 4'h8, 8'h00, 16'h1f},   '{OP_RD, 4'h9, 8'h00, 16'h1f},
    '{OP_RD, 4'ha, 8'h00, 16'h1f},   '{OP_RD, 4'hb, 8'h00, 16'hff},
    '{OP_RD, 4'hc, 8'h00, 16'hff},   '{OP_RD, 4'hd, 8'h00, 16'h0f},
    '{OP_PIN, 4'he, 8'h00, 16'h00},  '{OP_PIN, 4'hf, 8'h00, 16'h00},
    // both ports as outputs
    '{OP_WR, 4'h7, 8'hc0, 16'd0},    '{OP_RD, 4'he, 8'h00, 16'hff},
    '{OP_RD, 4'hf, 8'h00, 16'hff},
    // fixed volume, tones and noise off
    '{OP_WR, 4'h7, 8'h3f, 16'd0},    '{OP_VOL, 4'h8, 8'h00, 16'd0},
    '{OP_VOL, 4'h8, 8'h05, 16'd10},  '{OP_VOL, 4'h8, 8'h08, 16'd17},
    '{OP_VOL, 4'h8, 8'h0f, 16'd31},
    // tone A alone, spacing is 32 clocks per period unit
    '{OP_WR, 4'h1, 8'h00, 16'd0},    '{OP_WR, 4'h8, 8'h0f, 16'd0},
    '{OP_WR, 4'h7, 8'h3e, 16'd0},    '{OP_WR, 4'h0, 8'h01, 16'd0},
    '{OP_MEAS, 4'h0, 8'h00, 16'd32}, '{OP_WR, 4'h0, 8'h05, 16'd0},
    '{OP_MEAS, 4'h0, 8'h00, 16'd160}, '{OP_WR, 4'h0, 8'h00, 16'd0},
    '{OP_MEAS, 4'h0, 8'h00, 16'd32},
    // envelope on voice A, period 1, settle waits over 32 steps
    '{OP_WR, 4'h7, 8'h3f, 16'd0},    '{OP_WR, 4'h8, 8'h10, 16'd0},
    '{OP_WR, 4'hb, 8'h01, 16'd0},    '{OP_WR, 4'hc, 8'h00, 16'd0},
    '{OP_WR, 4'hd, 8'h00, 16'd0},    '{OP_WAIT, 4'h0, 8'h00, 16'd9000},
    '{OP_AMP, 4'h0, 8'h00, 16'd0},   '{OP_WR, 4'hd, 8'h0d, 16'd0},
    '{OP_WAIT, 4'h0, 8'h00, 16'd9000}, '{OP_AMP, 4'h0, 8'h00, 16'd255},
    '{OP_WR, 4'hd, 8'h0b, 16'd0},    '{OP_WAIT, 4'h0, 8'h00, 16'd9000},
    '{OP_AMP, 4'h0, 8'h00, 16'd255},
    // restart by rewriting the shape
    '{OP_WR, 4'hd, 8'h0d, 16'd0},    '{OP_WAIT, 4'h0, 8'h00, 16'd8},
    '{OP_BELOW, 4'h0, 8'h00, 16'd255}, '{OP_WAIT, 4'h0, 8'h00, 16'd9000},
    '{OP_AMP, 4'h0, 8'h00, 16'd255}
};

// log level to linear amplitude, about 1.5 dB per step
localparam amp_t AMP_REF [0:31] = '{
    8'd0,   8'd1,   8'd2,   8'd2,   8'd2,   8'd3,   8'd3,   8'd4,
    8'd5,   8'd6,   8'd7,   8'd8,   8'd10,  8'd11,  8'd14,  8'd16,
    8'd19,  8'd23,  8'd27,  8'd32,  8'd38,  8'd45,  8'd54,  8'd64,
    8'd76,  8'd90,  8'd108, 8'd128, 8'd152, 8'd181, 8'd215, 8'd255
};

`endif

// ==== testbench/psg_tb.sv ====
// ================================================
// clk_en and sel stay high, cen16 every 16 clocks
// outputs sampled on the falling edge
// ================================================
`timescale 1ns/1ps

module psg_tb import psg_pkg::*; ();

    logic      clk;
    logic      rst_n;
    logic      clk_en;
    logic      sel;
    logic      cs_n;
    logic      wr_n;
    reg_addr_t addr;
    reg_byte_t din;
    reg_byte_t ioa_in;
    reg_byte_t iob_in;
    reg_byte_t dout;
    reg_byte_t ioa_out;
    reg_byte_t iob_out;
    mix_sum_t  sound;
    amp_t      a_out;
    amp_t      b_out;
    amp_t      c_out;
    int        errors;
    int        seed;

    `include "psg_tb_vectors.svh"

    psg_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .clk_en  (clk_en),
        .sel     (sel),
        .addr    (addr),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .din     (din),
        .ioa_in  (ioa_in),
        .iob_in  (iob_in),
        .dout    (dout),
        .sound   (sound),
        .a_out   (a_out),
        .b_out   (b_out),
        .c_out   (c_out),
        .ioa_out (ioa_out),
        .iob_out (iob_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // worst case clocks per row
    function automatic int row_cycles(input vec_row_t r);
        case (r.op)
            OP_WR:   return 2;
            OP_RD:   return 3;
            OP_PIN:  return 4;
            OP_VOL:  return 12;
            OP_MEAS: return 4 * int'(r.value);  // three edges plus alignment
            OP_WAIT: return int'(r.value);
            default: return 1;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    endtask

    task automatic bus_write(input reg_addr_t a, input reg_byte_t d);
        @(posedge clk);
        addr <= a;
        din  <= d;
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        @(posedge clk);  // write edge
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic bus_read(input reg_addr_t a);
        @(posedge clk);
        addr <= a;
        cs_n <= 1'b0;
        wr_n <= 1'b1;
        @(posedge clk);  // dout loads here
        cs_n <= 1'b1;
        @(negedge clk);
    endtask

    // falling edges until a_out leaves zero, call on a falling edge
    task automatic clocks_to_rise(output int n);
        amp_t prev;
        prev = a_out;
        @(negedge clk);
        n = 1;
        while (!(prev == 8'd0 && a_out != 8'd0)) begin
            prev = a_out;
            @(negedge clk);
            n++;
        end
    endtask

    // watchdog
    initial begin
        int limit;
        int cycles;
        limit = 2000;  // reset and first-edge slack
        for (int i = 0; i < NUM_VECTORS; i++)
            limit += row_cycles(VECTORS[i]);
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        vec_row_t  r;
        int        n;
        int        rnd;
        amp_t      amp;
        reg_byte_t pin;
        errors = 0;
        seed   = 32'hafb6;
        rst_n  = 1'b0;
        clk_en = 1'b1;
        sel    = 1'b1;
        cs_n   = 1'b1;
        wr_n   = 1'b1;
        addr   = '0;
        din    = '0;
        rnd    = $random(seed);
        ioa_in = rnd[7:0];
        iob_in = rnd[15:8];
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            r = VECTORS[i];
            case (r.op)
                OP_WR: bus_write(r.addr, r.data);
                OP_RD: begin
                    bus_read(r.addr);
                    if (dout != r.value[7:0])
                        report_mismatch("dout", int'(r.value[7:0]), int'(dout));
                    if (r.addr == REG_IO_A && ioa_out != r.value[7:0])
                        report_mismatch("ioa_out", int'(r.value[7:0]), int'(ioa_out));
                    if (r.addr == REG_IO_B && iob_out != r.value[7:0])
                        report_mismatch("iob_out", int'(r.value[7:0]), int'(iob_out));
                end
                OP_PIN: begin
                    @(posedge clk);
                    rnd = $random(seed);  // fresh pins each read
                    ioa_in <= rnd[7:0];
                    iob_in <= rnd[15:8];
                    bus_read(r.addr);
                    pin = (r.addr == REG_IO_A) ? ioa_in : iob_in;
                    if (dout != pin)
                        report_mismatch("dout", int'(pin), int'(dout));
                end
                OP_VOL: begin
                    bus_write(REG_VOL_A, r.data);
                    bus_write(REG_VOL_B, r.data);
                    bus_write(REG_VOL_C, r.data);
                    repeat (3) @(posedge clk);  // stage 1, stage 2, sound
                    @(negedge clk);
                    amp = AMP_REF[r.value[4:0]];
                    if (a_out != amp)
                        report_mismatch("a_out", int'(amp), int'(a_out));
                    if (b_out != amp)
                        report_mismatch("b_out", int'(amp), int'(b_out));
                    if (c_out != amp)
                        report_mismatch("c_out", int'(amp), int'(c_out));
                    if (int'(sound) != 3 * int'(amp))
                        report_mismatch("sound", 3 * int'(amp), int'(sound));
                end
                OP_MEAS: begin
                    @(negedge clk);
                    clocks_to_rise(n);  // may be cut short by the write
                    clocks_to_rise(n);
                    clocks_to_rise(n);  // one full period
                    if (n != int'(r.value))
                        report_mismatch("a_out period", int'(r.value), n);
                end
                OP_WAIT: repeat (int'(r.value)) @(posedge clk);
                OP_AMP: begin
                    @(negedge clk);
                    if (a_out != r.value[7:0])
                        report_mismatch("a_out", int'(r.value[7:0]), int'(a_out));
                end
                OP_BELOW: begin
                    @(negedge clk);
                    if (a_out >= r.value[7:0]) begin
                        errors++;
                        $display("Error at %0d ns: a_out is %0d, expected below %0d",
                                 $time, a_out, r.value[7:0]);
                    end
                end
                default: ;
            endcase
        end

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
